// ==== logic/ecc_counter_pkg.sv ====
package ecc_counter_pkg;

  localparam int nibble_bits = 4;
  localparam int check_bits = 3;

  // apb register map, byte addresses.
  localparam logic [7:0] addr_ctrl = 8'h00;
  localparam logic [7:0] addr_count = 8'h04;
  localparam logic [7:0] addr_parity = 8'h08;
  localparam logic [7:0] addr_inject_data = 8'h0C;
  localparam logic [7:0] addr_inject_parity = 8'h10;
  localparam logic [7:0] addr_status = 8'h14;
  localparam logic [7:0] addr_errcnt = 8'h18;

  // returns {c2, c1, c0}.
  function automatic logic [check_bits-1:0] hamming_encode(input logic [nibble_bits-1:0] d);
    return {d[0] ^ d[2] ^ d[3], d[0] ^ d[1] ^ d[3], d[0] ^ d[1] ^ d[2]};
  endfunction

  function automatic logic [check_bits-1:0] hamming_syndrome(
    input logic [nibble_bits-1:0] d,
    input logic [check_bits-1:0] c
  );
    return c ^ hamming_encode(d);
  endfunction

  // syndrome bit k set means check bit ck disagrees.
  function automatic logic [nibble_bits-1:0] correct_nibble(
    input logic [nibble_bits-1:0] d,
    input logic [check_bits-1:0] syn
  );
    case (syn)
      3'b110: return d ^ 4'b1000; // d3 feeds c2 and c1.
      3'b101: return d ^ 4'b0100;
      3'b011: return d ^ 4'b0010;
      3'b111: return d ^ 4'b0001;
      default: return d;
    endcase
  endfunction

  function automatic logic [check_bits-1:0] correct_check(
    input logic [check_bits-1:0] c,
    input logic [check_bits-1:0] syn
  );
    case (syn)
      3'b001, 3'b010, 3'b100: return c ^ syn;
      default: return c;
    endcase
  endfunction

endpackage

// ==== logic/protected_counter.sv ====
`timescale 1ns/100ps

module protected_counter
  import ecc_counter_pkg::*;
#(
  parameter int width = 32
)(
  input  logic clk,
  input  logic rst,
  input  logic run,
  input  logic [width-1:0] inject_data_mask,
  input  logic inject_data_stb,
  input  logic [check_bits*(width/nibble_bits)-1:0] inject_parity_mask,
  input  logic inject_parity_stb,
  input  logic [width-1:0] corrected_count,
  input  logic [check_bits*(width/nibble_bits)-1:0] corrected_parity,
  input  logic data_fix,
  input  logic parity_fix,
  output logic [width-1:0] count,
  output logic [check_bits*(width/nibble_bits)-1:0] parity,
  output logic parity_valid
);

  localparam int blocks = width / nibble_bits;
  localparam int parity_bits = check_bits * blocks;

  logic run_d;
  logic stop_edge;
  logic snap_held; // snapshot taken and not yet released by a restart.
  logic [parity_bits-1:0] snapshot;

  assign stop_edge = run_d & ~run;

  // the check bits only mean something while the count is frozen.
  assign parity_valid = snap_held & ~run;

  always_comb begin
    for (int i = 0; i < blocks; i++) begin
      snapshot[i*check_bits +: check_bits] = hamming_encode(count[i*nibble_bits +: nibble_bits]);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_d <= 1'b0;
      snap_held <= 1'b0;
    end else begin
      run_d <= run;
      if (run) begin
        snap_held <= 1'b0;
      end else if (stop_edge) begin
        snap_held <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (inject_data_stb) begin
      count <= count ^ inject_data_mask;
    end else if (data_fix) begin
      count <= corrected_count;
    end else if (run) begin
      count <= count + 1'b1; // wraps at the top.
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      parity <= '0;
    end else if (inject_parity_stb) begin
      parity <= parity ^ inject_parity_mask;
    end else if (stop_edge) begin
      parity <= snapshot;
    end else if (parity_fix) begin
      parity <= corrected_parity;
    end
  end

  // held check bits match the frozen count once any repair has landed.
  a_valid_matches_count: assert property (
    @(posedge clk) disable iff (rst)
    (parity_valid && !inject_data_stb && !inject_parity_stb && !data_fix && !parity_fix)
    |-> parity == snapshot);

  a_no_fix_while_running: assert property (
    @(posedge clk) disable iff (rst) run |-> !(data_fix || parity_fix));

endmodule

// ==== logic/syndrome_corrector.sv ====
`timescale 1ns/100ps

module syndrome_corrector
  import ecc_counter_pkg::*;
#(
  parameter int width = 32,
  parameter int cnt_width = 16
)(
  input  logic clk,
  input  logic rst,
  input  logic [width-1:0] count,
  input  logic [check_bits*(width/nibble_bits)-1:0] parity,
  input  logic parity_valid,
  output logic [width-1:0] corrected_count,
  output logic [check_bits*(width/nibble_bits)-1:0] corrected_parity,
  output logic data_fix,
  output logic parity_fix,
  output logic [cnt_width-1:0] data_fix_count,
  output logic [cnt_width-1:0] parity_fix_count
);

  localparam int blocks = width / nibble_bits;
  localparam int parity_bits = check_bits * blocks;

  logic [parity_bits-1:0] syndrome;
  logic [parity_bits-1:0] residue;
  logic [blocks-1:0] data_err;
  logic [blocks-1:0] check_err;

  always_comb begin
    for (int i = 0; i < blocks; i++) begin
      syndrome[i*check_bits +: check_bits] = hamming_syndrome(
          count[i*nibble_bits +: nibble_bits], parity[i*check_bits +: check_bits]);
      corrected_count[i*nibble_bits +: nibble_bits] = correct_nibble(
          count[i*nibble_bits +: nibble_bits], syndrome[i*check_bits +: check_bits]);
      corrected_parity[i*check_bits +: check_bits] = correct_check(
          parity[i*check_bits +: check_bits], syndrome[i*check_bits +: check_bits]);
      // a single set bit points at a check bit, more than one at a data bit.
      check_err[i] = $onehot(syndrome[i*check_bits +: check_bits]);
      data_err[i] = (syndrome[i*check_bits +: check_bits] != '0) && !check_err[i];
    end
  end

  assign data_fix = parity_valid & (|data_err);
  assign parity_fix = parity_valid & (|check_err);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_fix_count <= '0;
      parity_fix_count <= '0;
    end else begin
      if (data_fix && !(&data_fix_count)) begin
        data_fix_count <= data_fix_count + 1'b1;
      end
      if (parity_fix && !(&parity_fix_count)) begin
        parity_fix_count <= parity_fix_count + 1'b1;
      end
    end
  end

  // syndrome of the word after correction.
  always_comb begin
    for (int i = 0; i < blocks; i++) begin
      residue[i*check_bits +: check_bits] = hamming_syndrome(
          corrected_count[i*nibble_bits +: nibble_bits],
          corrected_parity[i*check_bits +: check_bits]);
    end
  end

  a_corrected_is_codeword: assert property (
    @(posedge clk) disable iff (rst) residue == '0);

endmodule

// ==== logic/apb_regs.sv ====
`timescale 1ns/100ps

module apb_regs
  import ecc_counter_pkg::*;
#(
  parameter int width = 32,
  parameter int cnt_width = 16
)(
  input  logic clk,
  input  logic rst,
  input  logic [7:0] paddr,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [31:0] pwdata,
  input  logic [width-1:0] count,
  input  logic [check_bits*(width/nibble_bits)-1:0] parity,
  input  logic parity_valid,
  input  logic [cnt_width-1:0] data_fix_count,
  input  logic [cnt_width-1:0] parity_fix_count,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic run,
  output logic [width-1:0] inject_data_mask,
  output logic inject_data_stb,
  output logic [check_bits*(width/nibble_bits)-1:0] inject_parity_mask,
  output logic inject_parity_stb
);

  localparam int parity_bits = check_bits * (width / nibble_bits);

  logic access;
  logic wr;
  logic addr_hit;
  logic [width-1:0] data_mask_q;
  logic [parity_bits-1:0] parity_mask_q;

  assign access = psel & penable;
  assign wr = access & pwrite;
  assign pready = 1'b1; // no wait states.

  // injection lands on the access edge itself, so the bad word is gone
  // before the next transfer can read it.
  assign inject_data_stb = wr & (paddr == addr_inject_data);
  assign inject_parity_stb = wr & (paddr == addr_inject_parity);
  assign inject_data_mask = pwdata[width-1:0];
  assign inject_parity_mask = pwdata[parity_bits-1:0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run <= 1'b0;
    end else if (wr && paddr == addr_ctrl) begin
      run <= pwdata[0];
    end
  end

  // last masks written, kept for readback.
  always_ff @(posedge clk) begin
    if (inject_data_stb) begin
      data_mask_q <= pwdata[width-1:0];
    end
    if (inject_parity_stb) begin
      parity_mask_q <= pwdata[parity_bits-1:0];
    end
  end

  always_comb begin
    prdata = '0;
    addr_hit = 1'b1;
    case (paddr)
      addr_ctrl: prdata[0] = run;
      addr_count: prdata[width-1:0] = count;
      addr_parity: prdata[parity_bits-1:0] = parity;
      addr_inject_data: prdata[width-1:0] = data_mask_q;
      addr_inject_parity: prdata[parity_bits-1:0] = parity_mask_q;
      addr_status: prdata[1:0] = {run, parity_valid};
      addr_errcnt: begin
        prdata[cnt_width-1:0] = data_fix_count;
        prdata[16 +: cnt_width] = parity_fix_count;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  assign pslverr = access & ~addr_hit;

  a_enable_needs_select: assert property (
    @(posedge clk) disable iff (rst) penable |-> psel);

  a_strobes_single: assert property (
    @(posedge clk) disable iff (rst)
    (inject_data_stb || inject_parity_stb) |=> !(inject_data_stb || inject_parity_stb));

endmodule

// ==== logic/ecc_counter_top.sv ====
`timescale 1ns/100ps

module ecc_counter_top
  import ecc_counter_pkg::*;
#(
  parameter int width = 32,
  parameter int cnt_width = 16
)(
  input  logic clk,
  input  logic rst,
  input  logic [7:0] paddr,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr
);

  localparam int parity_bits = check_bits * (width / nibble_bits);

  logic run;
  logic [width-1:0] inject_data_mask;
  logic inject_data_stb;
  logic [parity_bits-1:0] inject_parity_mask;
  logic inject_parity_stb;
  logic [width-1:0] count;
  logic [parity_bits-1:0] parity;
  logic parity_valid;
  logic [width-1:0] corrected_count;
  logic [parity_bits-1:0] corrected_parity;
  logic data_fix;
  logic parity_fix;
  logic [cnt_width-1:0] data_fix_count;
  logic [cnt_width-1:0] parity_fix_count;

  apb_regs #(
    .width(width),
    .cnt_width(cnt_width)
  ) i_apb_regs (
    .clk(clk),
    .rst(rst),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .pwdata(pwdata),
    .count(count),
    .parity(parity),
    .parity_valid(parity_valid),
    .data_fix_count(data_fix_count),
    .parity_fix_count(parity_fix_count),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .run(run),
    .inject_data_mask(inject_data_mask),
    .inject_data_stb(inject_data_stb),
    .inject_parity_mask(inject_parity_mask),
    .inject_parity_stb(inject_parity_stb)
  );

  protected_counter #(
    .width(width)
  ) i_protected_counter (
    .clk(clk),
    .rst(rst),
    .run(run),
    .inject_data_mask(inject_data_mask),
    .inject_data_stb(inject_data_stb),
    .inject_parity_mask(inject_parity_mask),
    .inject_parity_stb(inject_parity_stb),
    .corrected_count(corrected_count),
    .corrected_parity(corrected_parity),
    .data_fix(data_fix),
    .parity_fix(parity_fix),
    .count(count),
    .parity(parity),
    .parity_valid(parity_valid)
  );

  syndrome_corrector #(
    .width(width),
    .cnt_width(cnt_width)
  ) i_syndrome_corrector (
    .clk(clk),
    .rst(rst),
    .count(count),
    .parity(parity),
    .parity_valid(parity_valid),
    .corrected_count(corrected_count),
    .corrected_parity(corrected_parity),
    .data_fix(data_fix),
    .parity_fix(parity_fix),
    .data_fix_count(data_fix_count),
    .parity_fix_count(parity_fix_count)
  );

endmodule

// ==== test/apb_driver.svh ====
`ifndef APB_DRIVER_SVH
`define APB_DRIVER_SVH

// setup edge, access edge, then the bus goes idle.
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                         output int unsigned access_cycle);
  @(posedge clk);
  paddr <= addr;
  pwdata <= data;
  pwrite <= 1'b1;
  psel <= 1'b1;
  penable <= 1'b0;
  @(posedge clk);
  penable <= 1'b1;
  @(posedge clk); // access edge.
  access_cycle = cycle;
  psel <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
  @(posedge clk);
  paddr <= addr;
  pwrite <= 1'b0;
  psel <= 1'b1;
  penable <= 1'b0;
  @(posedge clk);
  penable <= 1'b1;
  @(negedge clk); // middle of the access cycle.
  data = prdata;
  err = pslverr;
  check_equal("PREADY", pready, 32'h1);
  @(posedge clk);
  psel <= 1'b0;
  penable <= 1'b0;
endtask

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
endfunction

`endif

// ==== test/tb_ecc_counter.sv ====
`timescale 1ns/100ps

module tb_ecc_counter
  import ecc_counter_pkg::*;
();

  // about 40 transfers of 3 cycles plus the run gaps, well under this.
  localparam int unsigned max_cycles = 4000;

  logic clk;
  logic rst;
  logic [7:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  int unsigned cycle = 0;
  logic [15:0] lfsr = 16'd14;

  `include "apb_driver.svh"

  ecc_counter_top #(
    .width(32),
    .cnt_width(16)
  ) i_ecc_counter_top (
    .clk(clk),
    .rst(rst),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  // {c2, c1, c0} of one nibble.
  function automatic logic [2:0] ref_check(input logic [3:0] d);
    logic c2;
    logic c1;
    logic c0;
    c2 = d[0] ^ d[2] ^ d[3];
    c1 = d[0] ^ d[1] ^ d[3];
    c0 = d[0] ^ d[1] ^ d[2];
    return {c2, c1, c0};
  endfunction

  function automatic logic [31:0] ref_parity(input logic [31:0] value);
    logic [31:0] p;
    p = '0;
    for (int i = 0; i < 8; i++) begin
      p[3*i +: 3] = ref_check(value[4*i +: 4]);
    end
    return p;
  endfunction

  function automatic logic [31:0] ref_errcnt(input int unsigned data_fixes,
                                             input int unsigned parity_fixes);
    return {parity_fixes[15:0], data_fixes[15:0]};
  endfunction

  // the injection edge replaces that edge's increment.
  function automatic logic [31:0] ref_count_injected(input logic [31:0] start_value,
      input int unsigned start_at, input int unsigned inject_at,
      input int unsigned stop_at, input logic [31:0] mask);
    logic [31:0] v;
    v = start_value + (inject_at - start_at - 1);
    v = v ^ mask;
    return v + (stop_at - inject_at);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // at most one flipped bit per nibble, never empty.
  task automatic random_data_mask(output logic [31:0] mask);
    logic [31:0] pick;
    mask = '0;
    for (int i = 0; i < 8; i++) begin
      draw_bits(3, pick);
      if (pick[2]) mask[4*i + pick[1:0]] = 1'b1;
    end
    if (mask == '0) mask[0] = 1'b1;
  endtask

  task automatic random_check_mask(output logic [31:0] mask);
    logic [31:0] pick;
    mask = '0;
    for (int i = 0; i < 8; i++) begin
      draw_bits(2, pick);
      if (pick[1:0] != 2'd3) mask[3*i + pick[1:0]] = 1'b1; // 3 leaves the group alone.
    end
    if (mask == '0) mask[0] = 1'b1;
  endtask

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("Something failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic err;
    logic [31:0] count_exp;
    logic [31:0] mask;
    int unsigned start_at;
    int unsigned stop_at;
    int unsigned inject_at;
    int unsigned data_fixes;
    int unsigned parity_fixes;
    rst = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    count_exp = '0;
    data_fixes = 0;
    parity_fixes = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    apb_read(addr_count, rd, err);
    check_equal("COUNT after reset", rd, 32'h0);
    apb_read(addr_parity, rd, err);
    check_equal("PARITY after reset", rd, 32'h0);
    apb_read(addr_status, rd, err);
    check_equal("STATUS after reset", rd, 32'h0);
    apb_read(addr_errcnt, rd, err);
    check_equal("ERRCNT after reset", rd, 32'h0);

    // count for a while, then freeze.
    apb_write(addr_ctrl, 32'h1, start_at);
    repeat (37) @(posedge clk);
    apb_write(addr_ctrl, 32'h0, stop_at);
    count_exp = count_exp + (stop_at - start_at);
    apb_read(addr_count, rd, err);
    check_equal("COUNT after stop", rd, count_exp);
    apb_read(addr_status, rd, err);
    check_equal("STATUS after stop", rd, 32'h1);
    apb_read(addr_parity, rd, err);
    check_equal("PARITY after stop", rd, ref_parity(count_exp));

    repeat (4) begin
      random_data_mask(mask);
      apb_write(addr_inject_data, mask, inject_at);
      data_fixes++;
      apb_read(addr_count, rd, err);
      check_equal("COUNT after data flip", rd, count_exp);
      apb_read(addr_errcnt, rd, err);
      check_equal("ERRCNT after data flip", rd, ref_errcnt(data_fixes, parity_fixes));
      apb_read(addr_inject_data, rd, err);
      check_equal("data mask readback", rd, mask);
    end

    repeat (4) begin
      random_check_mask(mask);
      apb_write(addr_inject_parity, mask, inject_at);
      parity_fixes++;
      apb_read(addr_parity, rd, err);
      check_equal("PARITY after check flip", rd, ref_parity(count_exp));
      apb_read(addr_errcnt, rd, err);
      check_equal("ERRCNT after check flip", rd, ref_errcnt(data_fixes, parity_fixes));
      apb_read(addr_inject_parity, rd, err);
      check_equal("check mask readback", rd, mask);
    end

    // no protection while running, the flip stays.
    apb_write(addr_ctrl, 32'h1, start_at);
    repeat (9) @(posedge clk);
    random_data_mask(mask);
    apb_write(addr_inject_data, mask, inject_at);
    repeat (5) @(posedge clk);
    apb_write(addr_ctrl, 32'h0, stop_at);
    count_exp = ref_count_injected(count_exp, start_at, inject_at, stop_at, mask);
    apb_read(addr_count, rd, err);
    check_equal("COUNT after running flip", rd, count_exp);
    apb_read(addr_errcnt, rd, err);
    check_equal("ERRCNT after running flip", rd, ref_errcnt(data_fixes, parity_fixes));
    apb_read(addr_parity, rd, err);
    check_equal("PARITY after running flip", rd, ref_parity(count_exp));

    apb_read(8'h20, rd, err);
    check_equal("PSLVERR at 0x20", err, 32'h1);
    check_equal("read of 0x20", rd, 32'h0);
    apb_read(addr_ctrl, rd, err);
    check_equal("PSLVERR at CTRL", err, 32'h0);
    check_equal("CTRL while stopped", rd, 32'h0);
    apb_write(addr_ctrl, 32'h1, start_at);
    apb_read(addr_ctrl, rd, err);
    check_equal("CTRL while running", rd, 32'h1);
    apb_read(addr_status, rd, err);
    check_equal("STATUS while running", rd, 32'h2);
    apb_write(addr_ctrl, 32'h0, stop_at);
    count_exp = count_exp + (stop_at - start_at);
    apb_read(addr_count, rd, err);
    check_equal("COUNT after last run", rd, count_exp);

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+test
logic/ecc_counter_pkg.sv
logic/protected_counter.sv
logic/syndrome_corrector.sv
logic/apb_regs.sv
logic/ecc_counter_top.sv
test/tb_ecc_counter.sv

// ==== Bender.yml ====
package:
  name: ecc_counter

sources:
  - logic/ecc_counter_pkg.sv
  - logic/protected_counter.sv
  - logic/syndrome_corrector.sv
  - logic/apb_regs.sv
  - logic/ecc_counter_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ecc_counter.sv
